//--- hdl/a8_glue_pkg.sv
// Types, packed buses and constants shared by the glue logic between the
// 8-bit computer core and its host firmware
// Every design module pulls these in with a wildcard import
`default_nettype none

package a8_glue_pkg;

	// ============================================================
	// Widths with a meaning
	// ============================================================
	typedef logic [14:0]       rom_addr_t;
	typedef logic [7:0]        rom_byte_t;
	typedef logic [13:0]       load_addr_t;
	typedef logic [13:0]       rom_off_t;
	typedef logic [8:0]        buf_addr_t;
	typedef logic [31:0]       sd_lba_t;
	typedef logic [7:0]        drive_mask_t;
	typedef logic [2:0]        drive_num_t;
	typedef logic [31:0]       fw_word_t;
	typedef logic signed [7:0] axis_t;

	// Machine and OS choice, same coding as the menu bits
	typedef enum logic [1:0] {
		XL_BASIC = 2'd0,
		XL       = 2'd1,
		OS_A     = 2'd2,
		OS_B     = 2'd3
	} machine_e;

	// ============================================================
	// Packed buses
	// ============================================================
	// Host download port
	typedef struct packed {
		logic       download;
		logic       wr;
		load_addr_t addr;
		rom_byte_t  data;
		logic [7:0] index;
	} ioctl_t;

	// ROM slot write strobes, at most one set
	typedef struct packed {
		logic xl;
		logic basic;
		logic osa;
		logic osb;
	} rom_wr_t;

	// Drive firmware control register
	typedef struct packed {
		logic       lba_sel;
		logic       block_rd;
		logic       block_wr;
		drive_num_t drive;
	} fw_ctrl_t;

	// Drive firmware status register
	typedef struct packed {
		logic       io_done;
		logic       mounted;
		drive_num_t fileno;
		logic [1:0] filetype;
		logic       readonly;
	} fw_status_t;

	// Mouse packet as the host sends it, bit 24 down to bit 0
	typedef struct packed {
		logic       strobe;
		rom_byte_t  y_move;
		rom_byte_t  x_move;
		logic [1:0] overflow;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] spare;
		logic [1:0] buttons;
	} mouse_pkt_t;

	// ============================================================
	// Constants
	// ============================================================
	localparam rom_byte_t PAD_BYTE = 8'hFF;
	localparam int MOUSE_STEP_MAX = 10;

	// Download index numbers, low six bits
	localparam logic [5:0] IDX_XL_OS = 6'd4;
	localparam logic [5:0] IDX_BASIC = 6'd5;
	localparam logic [5:0] IDX_OS_A  = 6'd6;
	localparam logic [5:0] IDX_OS_B  = 6'd7;

endpackage

`default_nettype wire

//--- hdl/sys_ctrl.sv
// System control for the ROM downloads
// Latches the machine choice while reset is held, turns the download index
// into slot write strobes and raises a cold reset of LOAD_RESET_CYCLES
// cycles after a download into a slot that the running machine reads
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl
	import a8_glue_pkg::*;
#(
	parameter int LOAD_RESET_CYCLES = 1000
) (
	input  wire logic     clk_sys,
	input  wire logic     areset,
	input  wire machine_e machine_i,
	input  wire ioctl_t   ioctl_i,
	output machine_e      machine_o,
	output rom_wr_t       rom_wr_o,
	output logic          cold_reset_o
);

	localparam int CNT_W = $clog2(LOAD_RESET_CYCLES + 1);

	machine_e         machine_q;
	logic [5:0]       idx;
	logic             in_use;
	logic             in_use_q;
	logic             dl_q;
	logic [CNT_W-1:0] rst_cnt;

	assign idx = ioctl_i.index[5:0];

	// Selection only changes while the core sits in reset
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			machine_q <= machine_i;
		end
	end

	assign machine_o = machine_q;

	always_comb begin
		rom_wr_o.xl    = ioctl_i.wr && (idx == IDX_XL_OS);
		rom_wr_o.basic = ioctl_i.wr && (idx == IDX_BASIC);
		rom_wr_o.osa   = ioctl_i.wr && (idx == IDX_OS_A);
		rom_wr_o.osb   = ioctl_i.wr && (idx == IDX_OS_B);
	end

	// Slot of this download is one the current machine reads
	always_comb begin
		case (idx)
			IDX_XL_OS: in_use = (machine_q == XL_BASIC) || (machine_q == XL);
			IDX_BASIC: in_use = (machine_q == XL_BASIC);
			IDX_OS_A:  in_use = (machine_q == OS_A);
			IDX_OS_B:  in_use = (machine_q == OS_B);
			default:   in_use = 1'b0;
		endcase
	end

	// ============================================================
	// Cold reset after a download ends
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			dl_q         <= 1'b0;
			in_use_q     <= 1'b0;
			cold_reset_o <= 1'b0;
			rst_cnt      <= '0;
		end else begin
			dl_q <= ioctl_i.download;
			if (ioctl_i.download) begin
				in_use_q <= in_use;
			end

			if (dl_q && !ioctl_i.download) begin
				cold_reset_o <= in_use_q;
				rst_cnt      <= CNT_W'(LOAD_RESET_CYCLES - 1);
			end else if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 1'b1;
			end else begin
				cold_reset_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/rom_store.sv
// System ROM slots for the core
// XL OS, OS-A and OS-B are 16K slots holding right-aligned images with pad
// bytes below them; BASIC is an 8K slot; core reads return one cycle later
`timescale 1ns/1ps
`default_nettype none

module rom_store
	import a8_glue_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       areset,
	input  wire machine_e   machine_i,
	input  wire rom_wr_t    rom_wr_i,
	input  wire load_addr_t load_addr_i,
	input  wire rom_byte_t  load_data_i,
	input  wire rom_addr_t  rom_addr_i,
	output rom_byte_t       rom_data_o
);

	localparam rom_off_t SLOT_LAST = 14'h3FFF;

	// Padded slots by index: 0 XL OS, 1 OS-A, 2 OS-B
	logic [2:0] slot_wr;
	rom_off_t   slot_off [3];
	rom_byte_t  slot_q [3];
	rom_byte_t  basic_mem [8192];
	rom_byte_t  basic_q;

	logic       use_basic;
	logic [1:0] slot_sel;
	logic       below_off;
	logic       use_basic_q;
	logic       use_slot_q;
	logic [1:0] slot_sel_q;
	logic       below_off_q;

	assign slot_wr = {rom_wr_i.osb, rom_wr_i.osa, rom_wr_i.xl};

	// Last byte written fixes where the image starts
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			for (int i = 0; i < 3; i++) begin
				slot_off[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (slot_wr[i]) begin
					slot_off[i] <= SLOT_LAST - load_addr_i;
				end
			end
		end
	end

	// ============================================================
	// Slot memories
	// ============================================================
	for (genvar g = 0; g < 3; g++) begin : g_slot
		rom_byte_t mem [16384];
		rom_off_t  rd_addr;

		assign rd_addr = rom_addr_i[13:0] - slot_off[g];

		always_ff @(posedge clk_sys) begin
			if (slot_wr[g]) begin
				mem[load_addr_i] <= load_data_i;
			end
			slot_q[g] <= mem[rd_addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr_i.basic) begin
			basic_mem[load_addr_i[12:0]] <= load_data_i;
		end
		basic_q <= basic_mem[rom_addr_i[12:0]];
	end

	// ============================================================
	// Region choice, piped alongside the memory read
	// ============================================================
	always_comb begin
		use_basic = (rom_addr_i[14:13] == 2'b00) && (machine_i == XL_BASIC);
		case (machine_i)
			OS_A:    slot_sel = 2'd1;
			OS_B:    slot_sel = 2'd2;
			default: slot_sel = 2'd0;
		endcase
		below_off = rom_addr_i[13:0] < slot_off[slot_sel];
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			use_basic_q <= 1'b0;
			use_slot_q  <= 1'b0;
			slot_sel_q  <= 2'd0;
			below_off_q <= 1'b0;
		end else begin
			use_basic_q <= use_basic;
			use_slot_q  <= rom_addr_i[14];
			slot_sel_q  <= slot_sel;
			below_off_q <= below_off;
		end
	end

	always_comb begin
		if (use_basic_q) begin
			rom_data_o = basic_q;
		end else if (use_slot_q && !below_off_q) begin
			rom_data_o = slot_q[slot_sel_q];
		end else begin
			rom_data_o = PAD_BYTE;
		end
	end

endmodule

`default_nettype wire

//--- hdl/disk_bridge.sv
// Bridge between the drive firmware registers and the host block device
// Holds the 512-byte sector buffer shared by both sides, turns firmware
// strobes into buffer accesses and block requests, and records mount info
`timescale 1ns/1ps
`default_nettype none

module disk_bridge
	import a8_glue_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        areset,
	input  wire fw_ctrl_t    fw_ctrl_i,
	input  wire logic        fw_data_wr_i,
	input  wire logic        fw_data_rd_i,
	input  wire logic        fw_io_wr_i,
	input  wire fw_word_t    fw_data_i,
	input  wire drive_mask_t sd_ack_i,
	input  wire buf_addr_t   sd_buff_addr_i,
	input  wire rom_byte_t   sd_buff_dout_i,
	input  wire logic        sd_buff_wr_i,
	input  wire drive_mask_t img_mounted_i,
	input  wire logic        img_readonly_i,
	input  wire sd_lba_t     img_size_i,
	input  wire logic [1:0]  filetype_i,
	output fw_status_t       fw_status_o,
	output fw_word_t         fw_data_o,
	output sd_lba_t          sd_lba_o,
	output drive_mask_t      sd_rd_o,
	output drive_mask_t      sd_wr_o,
	output rom_byte_t        sd_buff_din_o
);

	rom_byte_t  buf_mem [512];
	buf_addr_t  fw_ptr;
	rom_byte_t  fw_buf_q;

	logic       data_wr_q;
	logic       data_rd_q;
	logic       blk_rd_q;
	logic       blk_wr_q;
	logic       ack_q;
	logic       mnt_q;
	logic       data_wr_rise;
	logic       data_rd_fall;
	logic       blk_rd_rise;
	logic       blk_wr_rise;
	logic       ack_any;
	logic       mnt_rise;
	logic       buf_wr;

	logic       io_done;
	logic       mounted;
	logic       readonly;
	drive_num_t fileno;
	drive_num_t mnt_hi;
	logic [1:0] filetype;
	sd_lba_t    file_size;

	assign data_wr_rise = fw_data_wr_i && !data_wr_q;
	assign data_rd_fall = data_rd_q && !fw_data_rd_i;
	assign blk_rd_rise  = fw_ctrl_i.block_rd && !blk_rd_q;
	assign blk_wr_rise  = fw_ctrl_i.block_wr && !blk_wr_q;
	assign ack_any      = |sd_ack_i;
	assign mnt_rise     = (|img_mounted_i) && !mnt_q;
	assign buf_wr       = data_wr_rise && !fw_ctrl_i.lba_sel;

	// ============================================================
	// Sector buffer, host port and firmware port
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (sd_buff_wr_i) begin
			buf_mem[sd_buff_addr_i] <= sd_buff_dout_i;
		end
		if (buf_wr) begin
			buf_mem[fw_ptr] <= fw_data_i[7:0];
		end
		sd_buff_din_o <= buf_mem[sd_buff_addr_i];
		fw_buf_q      <= buf_mem[fw_ptr];
	end

	// Highest mounted drive wins
	always_comb begin
		mnt_hi = '0;
		for (int i = 0; i < 8; i++) begin
			if (img_mounted_i[i]) begin
				mnt_hi = drive_num_t'(i);
			end
		end
	end

	// ============================================================
	// Strobe edges, pointer and block requests
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			data_wr_q <= 1'b0;
			data_rd_q <= 1'b0;
			blk_rd_q  <= 1'b0;
			blk_wr_q  <= 1'b0;
			ack_q     <= 1'b0;
			mnt_q     <= 1'b0;
			fw_ptr    <= '0;
			io_done   <= 1'b0;
			mounted   <= 1'b0;
			sd_rd_o   <= '0;
			sd_wr_o   <= '0;
		end else begin
			data_wr_q <= fw_data_wr_i;
			data_rd_q <= fw_data_rd_i;
			blk_rd_q  <= fw_ctrl_i.block_rd;
			blk_wr_q  <= fw_ctrl_i.block_wr;
			ack_q     <= ack_any;
			mnt_q     <= |img_mounted_i;

			if (buf_wr || data_rd_fall) begin
				fw_ptr <= fw_ptr + 1'b1;
			end
			if (fw_io_wr_i) begin
				fw_ptr <= '0;
			end

			if (blk_rd_rise) begin
				sd_rd_o[fw_ctrl_i.drive] <= 1'b1;
				io_done                  <= 1'b0;
			end
			if (blk_wr_rise) begin
				sd_wr_o[fw_ctrl_i.drive] <= 1'b1;
				io_done                  <= 1'b0;
			end
			// Host took the request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end
			if (ack_q && !ack_any) begin
				io_done <= 1'b1;
			end

			if (mnt_rise) begin
				mounted <= ~mounted;
			end
		end
	end

	// Registers loaded from the firmware and the host
	always_ff @(posedge clk_sys) begin
		if (data_wr_rise && fw_ctrl_i.lba_sel) begin
			sd_lba_o <= fw_data_i;
		end
		if (mnt_rise) begin
			fileno    <= mnt_hi;
			filetype  <= filetype_i;
			readonly  <= img_readonly_i | img_mounted_i[4] | img_mounted_i[5];
			file_size <= img_size_i;
		end
	end

	always_comb begin
		fw_status_o.io_done  = io_done;
		fw_status_o.mounted  = mounted;
		fw_status_o.fileno   = fileno;
		fw_status_o.filetype = filetype;
		fw_status_o.readonly = readonly;
	end

	assign fw_data_o = fw_ctrl_i.lba_sel ? file_size : {24'd0, fw_buf_q};

endmodule

`default_nettype wire

//--- hdl/mouse_axis.sv
// Paddle emulation from mouse packets
// Each packet adds half its clamped movement to a signed axis pair; the
// real analog stick takes over again as soon as it moves or the CPU halts
`timescale 1ns/1ps
`default_nettype none

module mouse_axis
	import a8_glue_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        areset,
	input  wire mouse_pkt_t  mouse_i,
	input  wire logic [15:0] analog_i,
	input  wire logic [1:0]  joy_fire_i,
	input  wire logic        cpu_halt_i,
	input  wire logic        invert_y_i,
	output axis_t            axis_x_o,
	output axis_t            axis_y_o,
	output logic [1:0]       fire_o
);

	localparam logic signed [8:0] STEP_MAX = 9'(MOUSE_STEP_MAX);
	localparam logic signed [8:0] AXIS_MAX = 9'sd127;
	localparam logic signed [8:0] AXIS_MIN = -9'sd128;

	logic              stb_q;
	logic              emu;
	axis_t             acc_x;
	axis_t             acc_y;
	logic signed [8:0] dx;
	logic signed [8:0] dy;
	logic signed [8:0] nx;
	logic signed [8:0] ny;

	function automatic logic signed [8:0] clamp_step(input logic signed [8:0] d);
		if (d > STEP_MAX) begin
			return STEP_MAX;
		end else if (d < -STEP_MAX) begin
			return -STEP_MAX;
		end
		return d;
	endfunction

	function automatic axis_t clamp_axis(input logic signed [8:0] s);
		if (s > AXIS_MAX) begin
			return 8'sh7F;
		end else if (s < AXIS_MIN) begin
			return -8'sd128;
		end
		return s[7:0];
	endfunction

	// Half movement, sign bit on top
	assign dx = clamp_step({{2{mouse_i.x_sign}}, mouse_i.x_move[7:1]});
	assign dy = clamp_step({{2{mouse_i.y_sign}}, mouse_i.y_move[7:1]});
	assign nx = 9'(acc_x) + dx;
	assign ny = invert_y_i ? (9'(acc_y) - dy) : (9'(acc_y) + dy);

	always_ff @(posedge clk_sys) begin
		stb_q <= mouse_i.strobe;
	end

	always_ff @(posedge clk_sys) begin
		if (areset || (analog_i != '0) || cpu_halt_i) begin
			emu   <= 1'b0;
			acc_x <= '0;
			acc_y <= '0;
		end else if (mouse_i.strobe != stb_q) begin
			emu   <= 1'b1;
			acc_x <= clamp_axis(nx);
			acc_y <= clamp_axis(ny);
		end
	end

	assign axis_x_o = emu ? acc_x : axis_t'(analog_i[7:0]);
	assign axis_y_o = emu ? acc_y : axis_t'(analog_i[15:8]);
	assign fire_o   = emu ? mouse_i.buttons : joy_fire_i;

endmodule

`default_nettype wire

//--- hdl/a8_glue_top.sv
// Top level of the core glue logic
// Joins the system control, the ROM store, the disk block bridge and the
// mouse paddle emulation; LOAD_RESET_CYCLES sets the cold-reset pulse length
`timescale 1ns/1ps
`default_nettype none

module a8_glue_top
	import a8_glue_pkg::*;
#(
	parameter int LOAD_RESET_CYCLES = 1000
) (
	input  wire logic        clk_sys,
	input  wire logic        areset,
	input  wire machine_e    machine_i,
	input  wire ioctl_t      ioctl_i,
	input  wire rom_addr_t   rom_addr_i,
	input  wire fw_ctrl_t    fw_ctrl_i,
	input  wire logic        fw_data_wr_i,
	input  wire logic        fw_data_rd_i,
	input  wire logic        fw_io_wr_i,
	input  wire fw_word_t    fw_data_i,
	input  wire drive_mask_t sd_ack_i,
	input  wire buf_addr_t   sd_buff_addr_i,
	input  wire rom_byte_t   sd_buff_dout_i,
	input  wire logic        sd_buff_wr_i,
	input  wire drive_mask_t img_mounted_i,
	input  wire logic        img_readonly_i,
	input  wire sd_lba_t     img_size_i,
	input  wire mouse_pkt_t  mouse_i,
	input  wire logic [15:0] analog_i,
	input  wire logic [1:0]  joy_fire_i,
	input  wire logic        cpu_halt_i,
	input  wire logic        invert_y_i,
	output rom_byte_t        rom_data_o,
	output logic             cold_reset_o,
	output fw_status_t       fw_status_o,
	output fw_word_t         fw_data_o,
	output sd_lba_t          sd_lba_o,
	output drive_mask_t      sd_rd_o,
	output drive_mask_t      sd_wr_o,
	output rom_byte_t        sd_buff_din_o,
	output axis_t            axis_x_o,
	output axis_t            axis_y_o,
	output logic [1:0]       fire_o
);

	machine_e machine;
	rom_wr_t  rom_wr;

	// ============================================================
	// System ROM
	// ============================================================
	sys_ctrl #(
		.LOAD_RESET_CYCLES(LOAD_RESET_CYCLES)
	) u_sys_ctrl (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.machine_i    (machine_i),
		.ioctl_i      (ioctl_i),
		.machine_o    (machine),
		.rom_wr_o     (rom_wr),
		.cold_reset_o (cold_reset_o)
	);

	rom_store u_rom_store (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.machine_i   (machine),
		.rom_wr_i    (rom_wr),
		.load_addr_i (ioctl_i.addr),
		.load_data_i (ioctl_i.data),
		.rom_addr_i  (rom_addr_i),
		.rom_data_o  (rom_data_o)
	);

	// ============================================================
	// Disk and input devices
	// ============================================================
	disk_bridge u_disk_bridge (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.fw_ctrl_i      (fw_ctrl_i),
		.fw_data_wr_i   (fw_data_wr_i),
		.fw_data_rd_i   (fw_data_rd_i),
		.fw_io_wr_i     (fw_io_wr_i),
		.fw_data_i      (fw_data_i),
		.sd_ack_i       (sd_ack_i),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.filetype_i     (ioctl_i.index[7:6]),
		.fw_status_o    (fw_status_o),
		.fw_data_o      (fw_data_o),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_buff_din_o  (sd_buff_din_o)
	);

	mouse_axis u_mouse_axis (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.mouse_i    (mouse_i),
		.analog_i   (analog_i),
		.joy_fire_i (joy_fire_i),
		.cpu_halt_i (cpu_halt_i),
		.invert_y_i (invert_y_i),
		.axis_x_o   (axis_x_o),
		.axis_y_o   (axis_y_o),
		.fire_o     (fire_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_a8_glue.sv
// Directed testbench for the core glue logic
// Covers ROM download and padding, the cold-reset pulse, block requests,
// the sector buffer, mount reporting with a machine change and the mouse
// paddle emulation; the first mismatch stops the run
`timescale 1ns/1ps
`default_nettype none

module tb_a8_glue
	import a8_glue_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int XL_SIZE    = 4096;
	localparam int BASIC_SIZE = 256;
	localparam int OSA_SIZE   = 64;
	localparam int OSB_SIZE   = 2048;

	// Every image byte costs one cycle to load and one to read back
	localparam int LOAD_CYCLES     = 2 * XL_SIZE + BASIC_SIZE + OSA_SIZE + OSB_SIZE;
	localparam int READ_CYCLES     = XL_SIZE + BASIC_SIZE + OSB_SIZE + 200;
	localparam int WATCHDOG_CYCLES = 2 * (LOAD_CYCLES + READ_CYCLES) + 2000;

	logic        clk_sys;
	logic        areset;
	machine_e    machine_i;
	ioctl_t      ioctl_i;
	rom_addr_t   rom_addr_i;
	fw_ctrl_t    fw_ctrl_i;
	logic        fw_data_wr_i;
	logic        fw_data_rd_i;
	logic        fw_io_wr_i;
	fw_word_t    fw_data_i;
	drive_mask_t sd_ack_i;
	buf_addr_t   sd_buff_addr_i;
	rom_byte_t   sd_buff_dout_i;
	logic        sd_buff_wr_i;
	drive_mask_t img_mounted_i;
	logic        img_readonly_i;
	sd_lba_t     img_size_i;
	mouse_pkt_t  mouse_i;
	logic [15:0] analog_i;
	logic [1:0]  joy_fire_i;
	logic        cpu_halt_i;
	logic        invert_y_i;

	rom_byte_t   rom_data_o;
	logic        cold_reset_o;
	fw_status_t  fw_status_o;
	fw_word_t    fw_data_o;
	sd_lba_t     sd_lba_o;
	drive_mask_t sd_rd_o;
	drive_mask_t sd_wr_o;
	rom_byte_t   sd_buff_din_o;
	axis_t       axis_x_o;
	axis_t       axis_y_o;
	logic [1:0]  fire_o;

	// Reference images and paddle model
	rom_byte_t xl_img [XL_SIZE];
	rom_byte_t basic_img [BASIC_SIZE];
	rom_byte_t osa_img [OSA_SIZE];
	rom_byte_t osb_img [OSB_SIZE];
	int        fail_count;
	int        model_x;
	int        model_y;
	logic      model_emu;

	a8_glue_top #(
		.LOAD_RESET_CYCLES(16)
	) DUT (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.machine_i      (machine_i),
		.ioctl_i        (ioctl_i),
		.rom_addr_i     (rom_addr_i),
		.fw_ctrl_i      (fw_ctrl_i),
		.fw_data_wr_i   (fw_data_wr_i),
		.fw_data_rd_i   (fw_data_rd_i),
		.fw_io_wr_i     (fw_io_wr_i),
		.fw_data_i      (fw_data_i),
		.sd_ack_i       (sd_ack_i),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.mouse_i        (mouse_i),
		.analog_i       (analog_i),
		.joy_fire_i     (joy_fire_i),
		.cpu_halt_i     (cpu_halt_i),
		.invert_y_i     (invert_y_i),
		.rom_data_o     (rom_data_o),
		.cold_reset_o   (cold_reset_o),
		.fw_status_o    (fw_status_o),
		.fw_data_o      (fw_data_o),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_buff_din_o  (sd_buff_din_o),
		.axis_x_o       (axis_x_o),
		.axis_y_o       (axis_y_o),
		.fire_o         (fire_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$fatal(1, "Run stopped by the watchdog");
	end

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic stop_failed();
		fail_count++;
		$display("TESTS FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic compare_byte(input string name, input rom_byte_t exp, input rom_byte_t act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_axis(input string name, input axis_t exp, input axis_t act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_status(input string name, input fw_status_t exp,
			input fw_status_t act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_word(input string name, input sd_lba_t exp, input sd_lba_t act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_mask(input string name, input drive_mask_t exp,
			input drive_mask_t act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			stop_failed();
		end
	endtask

	// ============================================================
	// Drivers, all entered and left just after a falling edge
	// ============================================================
	task automatic apply_reset(input machine_e sel);
		areset    = 1'b1;
		machine_i = sel;
		repeat (3) @(negedge clk_sys);
		areset = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic load_image(input logic [7:0] index, input int size);
		rom_byte_t b;
		ioctl_i.download = 1'b1;
		ioctl_i.index    = index;
		@(negedge clk_sys);
		for (int k = 0; k < size; k++) begin
			case (index[5:0])
				IDX_XL_OS: b = xl_img[k];
				IDX_BASIC: b = basic_img[k];
				IDX_OS_A:  b = osa_img[k];
				default:   b = osb_img[k];
			endcase
			ioctl_i.wr   = 1'b1;
			ioctl_i.addr = load_addr_t'(k);
			ioctl_i.data = b;
			@(negedge clk_sys);
		end
		ioctl_i.wr = 1'b0;
		@(negedge clk_sys);
		ioctl_i.download = 1'b0;
	endtask

	task automatic read_rom(input rom_addr_t addr, input rom_byte_t exp);
		rom_addr_i = addr;
		@(negedge clk_sys);
		compare_byte("rom_data_o", exp, rom_data_o);
	endtask

	task automatic fw_write(input fw_word_t data);
		fw_data_i    = data;
		fw_data_wr_i = 1'b1;
		repeat (2) @(negedge clk_sys);
		fw_data_wr_i = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic fw_read_step();
		fw_data_rd_i = 1'b1;
		repeat (2) @(negedge clk_sys);
		fw_data_rd_i = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic clear_pointer();
		fw_io_wr_i = 1'b1;
		repeat (2) @(negedge clk_sys);
		fw_io_wr_i = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// One block request on one drive, acknowledged by the host
	task automatic block_cycle(input logic is_write, input drive_num_t drive);
		drive_mask_t req;
		req                = drive_mask_t'(1) << drive;
		fw_ctrl_i.drive    = drive;
		fw_ctrl_i.block_rd = !is_write;
		fw_ctrl_i.block_wr = is_write;
		@(negedge clk_sys);
		compare_mask("sd_rd_o", is_write ? 8'h00 : req, sd_rd_o);
		compare_mask("sd_wr_o", is_write ? req : 8'h00, sd_wr_o);
		compare_bit("fw_status_o.io_done", 1'b0, fw_status_o.io_done);
		sd_ack_i = req;
		@(negedge clk_sys);
		compare_mask("sd_rd_o", 8'h00, sd_rd_o);
		compare_mask("sd_wr_o", 8'h00, sd_wr_o);
		sd_ack_i = 8'h00;
		for (int n = 0; n < 8 && !fw_status_o.io_done; n++) begin
			@(negedge clk_sys);
		end
		compare_bit("fw_status_o.io_done", 1'b1, fw_status_o.io_done);
		fw_ctrl_i.block_rd = 1'b0;
		fw_ctrl_i.block_wr = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// Half the movement with its sign, limited per packet
	function automatic int half_step(input logic sign, input rom_byte_t move);
		logic signed [7:0] h;
		int                d;
		h = {sign, move[7:1]};
		d = h;
		if (d > MOUSE_STEP_MAX) begin
			d = MOUSE_STEP_MAX;
		end else if (d < -MOUSE_STEP_MAX) begin
			d = -MOUSE_STEP_MAX;
		end
		return d;
	endfunction

	function automatic int limit_axis(input int v);
		if (v > 127) begin
			return 127;
		end else if (v < -128) begin
			return -128;
		end
		return v;
	endfunction

	task automatic send_packet(input rom_byte_t xm, input logic xs, input rom_byte_t ym,
			input logic ys, input logic [1:0] btn);
		int dy;
		mouse_i.x_move  = xm;
		mouse_i.x_sign  = xs;
		mouse_i.y_move  = ym;
		mouse_i.y_sign  = ys;
		mouse_i.buttons = btn;
		mouse_i.strobe  = ~mouse_i.strobe;
		if ((analog_i == '0) && !cpu_halt_i) begin
			dy        = invert_y_i ? -half_step(ys, ym) : half_step(ys, ym);
			model_x   = limit_axis(model_x + half_step(xs, xm));
			model_y   = limit_axis(model_y + dy);
			model_emu = 1'b1;
		end
		@(negedge clk_sys);
		if (model_emu) begin
			compare_axis("axis_x_o", axis_t'(model_x), axis_x_o);
			compare_axis("axis_y_o", axis_t'(model_y), axis_y_o);
			compare_bit("fire_o[0]", btn[0], fire_o[0]);
			compare_bit("fire_o[1]", btn[1], fire_o[1]);
		end else begin
			compare_axis("axis_x_o", axis_t'(analog_i[7:0]), axis_x_o);
			compare_axis("axis_y_o", axis_t'(analog_i[15:8]), axis_y_o);
			compare_bit("fire_o[0]", joy_fire_i[0], fire_o[0]);
			compare_bit("fire_o[1]", joy_fire_i[1], fire_o[1]);
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic rom_padding();
		load_image({2'b00, IDX_XL_OS}, XL_SIZE);
		@(negedge clk_sys);
		load_image({2'b00, IDX_BASIC}, BASIC_SIZE);
		@(negedge clk_sys);
		// 4K image sits at the top of the 16K slot
		read_rom(15'h4000, PAD_BYTE);
		read_rom(15'h6FFF, PAD_BYTE);
		for (int k = 0; k < 64; k++) begin
			read_rom(rom_addr_t'(15'h4000 + ($urandom % 16'h3000)), PAD_BYTE);
		end
		for (int k = 0; k < XL_SIZE; k++) begin
			read_rom(rom_addr_t'(15'h7000 + k), xl_img[k]);
		end
		for (int k = 0; k < BASIC_SIZE; k++) begin
			read_rom(rom_addr_t'(k), basic_img[k]);
		end
		read_rom(15'h2000, PAD_BYTE);
		for (int k = 0; k < 16; k++) begin
			read_rom(rom_addr_t'(15'h2000 + ($urandom % 16'h2000)), PAD_BYTE);
		end
	endtask

	task automatic cold_reset_pulse();
		int high_cycles;
		high_cycles = 0;
		load_image({2'b00, IDX_XL_OS}, XL_SIZE);
		for (int n = 0; n < 40; n++) begin
			@(negedge clk_sys);
			if (cold_reset_o) begin
				high_cycles++;
			end else if (high_cycles > 0) begin
				break;
			end
		end
		if (high_cycles != 16) begin
			$display("Fail at %0t ns: cold_reset_o high cycles expected 16, got %0d",
				$time, high_cycles);
			stop_failed();
		end
		// OS-A is not read by the XL machine
		load_image({2'b00, IDX_OS_A}, OSA_SIZE);
		for (int n = 0; n < 40; n++) begin
			@(negedge clk_sys);
			compare_bit("cold_reset_o", 1'b0, cold_reset_o);
		end
	endtask

	task automatic block_request();
		sd_lba_t lba;
		lba = $urandom;
		fw_ctrl_i.lba_sel = 1'b1;
		fw_write(lba);
		compare_word("sd_lba_o", lba, sd_lba_o);
		fw_ctrl_i.lba_sel = 1'b0;
		// Write request on drive 6, then read request on drive 2
		block_cycle(1'b1, 3'd6);
		block_cycle(1'b0, 3'd2);
	endtask

	task automatic sector_buffer();
		rom_byte_t fw_bytes [8];
		rom_byte_t host_bytes [8];
		clear_pointer();
		for (int k = 0; k < 8; k++) begin
			fw_bytes[k] = rom_byte_t'($urandom);
			fw_write({24'($urandom), fw_bytes[k]});
		end
		for (int k = 0; k < 8; k++) begin
			sd_buff_addr_i = buf_addr_t'(k);
			@(negedge clk_sys);
			compare_byte("sd_buff_din_o", fw_bytes[k], sd_buff_din_o);
		end
		for (int k = 0; k < 8; k++) begin
			host_bytes[k]  = rom_byte_t'($urandom);
			sd_buff_addr_i = buf_addr_t'(k);
			sd_buff_dout_i = host_bytes[k];
			sd_buff_wr_i   = 1'b1;
			@(negedge clk_sys);
		end
		sd_buff_wr_i = 1'b0;
		clear_pointer();
		for (int k = 0; k < 8; k++) begin
			compare_word("fw_data_o", {24'd0, host_bytes[k]}, fw_data_o);
			fw_read_step();
		end
	endtask

	task automatic mount_and_machine();
		fw_status_t exp_st;
		sd_lba_t    size;
		size           = $urandom;
		ioctl_i.index  = 8'h40;
		img_mounted_i  = 8'h20;
		img_size_i     = size;
		img_readonly_i = 1'b0;
		repeat (2) @(negedge clk_sys);
		img_mounted_i = 8'h00;
		repeat (2) @(negedge clk_sys);
		exp_st.io_done  = 1'b1;
		exp_st.mounted  = 1'b1;
		exp_st.fileno   = 3'd5;
		exp_st.filetype = 2'b01;
		exp_st.readonly = 1'b1;
		compare_status("fw_status_o", exp_st, fw_status_o);
		fw_ctrl_i.lba_sel = 1'b1;
		@(negedge clk_sys);
		compare_word("fw_data_o", size, fw_data_o);
		fw_ctrl_i.lba_sel = 1'b0;

		apply_reset(OS_B);
		exp_st.io_done = 1'b0;
		exp_st.mounted = 1'b0;
		compare_status("fw_status_o", exp_st, fw_status_o);
		load_image({2'b00, IDX_OS_B}, OSB_SIZE);
		@(negedge clk_sys);
		read_rom(15'h0000, PAD_BYTE);
		read_rom(15'h77FF, PAD_BYTE);
		for (int k = 0; k < OSB_SIZE; k++) begin
			read_rom(rom_addr_t'(15'h7800 + k), osb_img[k]);
		end
	endtask

	task automatic mouse_emulation();
		model_x   = 0;
		model_y   = 0;
		model_emu = 1'b0;
		for (int k = 0; k < 20; k++) begin
			send_packet(rom_byte_t'($urandom), 1'($urandom), rom_byte_t'($urandom),
				1'($urandom), 2'($urandom));
		end
		// Small moves stay under the step limit
		for (int k = 0; k < 10; k++) begin
			send_packet(rom_byte_t'($urandom % 16), 1'b0,
				rom_byte_t'(8'hF0 | ($urandom % 16)), 1'b1, 2'($urandom));
		end
		// Run x up and y down to the limits
		for (int k = 0; k < 30; k++) begin
			send_packet(8'hF0, 1'b0, 8'h10, 1'b1, 2'($urandom));
		end
		invert_y_i = 1'b1;
		for (int k = 0; k < 30; k++) begin
			send_packet(8'h00, 1'b1, 8'h20, 1'b1, 2'($urandom));
		end
		invert_y_i = 1'b0;

		// Real stick takes over, even against a packet in the same cycle
		analog_i   = 16'h9C35;
		joy_fire_i = 2'b10;
		model_emu  = 1'b0;
		model_x    = 0;
		model_y    = 0;
		@(negedge clk_sys);
		compare_axis("axis_x_o", axis_t'(8'h35), axis_x_o);
		compare_axis("axis_y_o", axis_t'(8'h9C), axis_y_o);
		compare_bit("fire_o[0]", 1'b0, fire_o[0]);
		compare_bit("fire_o[1]", 1'b1, fire_o[1]);
		send_packet(8'h40, 1'b0, 8'h40, 1'b0, 2'b01);
	endtask

	// ============================================================
	// Run
	// ============================================================
	initial begin
		fail_count     = 0;
		areset         = 1'b1;
		machine_i      = XL_BASIC;
		ioctl_i        = '0;
		rom_addr_i     = '0;
		fw_ctrl_i      = '0;
		fw_data_wr_i   = 1'b0;
		fw_data_rd_i   = 1'b0;
		fw_io_wr_i     = 1'b0;
		fw_data_i      = '0;
		sd_ack_i       = '0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		mouse_i        = '0;
		analog_i       = '0;
		joy_fire_i     = '0;
		cpu_halt_i     = 1'b0;
		invert_y_i     = 1'b0;

		void'($urandom(32'he7d3));
		foreach (xl_img[k]) xl_img[k] = rom_byte_t'($urandom);
		foreach (basic_img[k]) basic_img[k] = rom_byte_t'($urandom);
		foreach (osa_img[k]) osa_img[k] = rom_byte_t'($urandom);
		foreach (osb_img[k]) osb_img[k] = rom_byte_t'($urandom);

		apply_reset(XL_BASIC);
		rom_padding();
		cold_reset_pulse();
		block_request();
		sector_buffer();
		mount_and_machine();
		mouse_emulation();

		if (fail_count == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1, "Checks failed");
		end
	end

endmodule

`default_nettype wire

//--- compile.f
hdl/a8_glue_pkg.sv
hdl/sys_ctrl.sv
hdl/rom_store.sv
hdl/disk_bridge.sv
hdl/mouse_axis.sv
hdl/a8_glue_top.sv
testbench/tb_a8_glue.sv
